/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = pcpu_tb
FLIST = project.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FLIST)) include/pcpu_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

/* hw/pcpu_decode.sv */
module pcpu_decode
(
	input logic clock,
	input logic reset,
	input logic i_running,
	input pcpu_pkg::word_t i_id_ir,
	input logic i_take_branch,
	input pcpu_pkg::word_t i_ex_result,
	input pcpu_pkg::word_t i_mem_ir,
	input pcpu_pkg::word_t i_mem_result,
	input pcpu_pkg::word_t i_ddata,
	input pcpu_pkg::word_t i_wb_ir,
	input pcpu_pkg::word_t i_wb_result,
	input pcpu_pkg::word_t i_rf_a,
	input pcpu_pkg::word_t i_rf_b,
	input pcpu_pkg::word_t i_rf_s,
	output pcpu_pkg::reg_idx_t o_rd_a,
	output pcpu_pkg::reg_idx_t o_rd_b,
	output pcpu_pkg::reg_idx_t o_rd_s,
	output logic o_stall,
	output pcpu_pkg::word_t o_ex_ir,
	output pcpu_pkg::word_t o_opa,
	output pcpu_pkg::word_t o_opb,
	output pcpu_pkg::word_t o_smdr
);
	import pcpu_pkg::*;

	opcode_t op;
	logic use_a;
	logic use_b;
	logic use_s;
	logic a_is_r1;
	logic load_use;
	word_t imm;
	word_t mem_val;
	word_t fwd_a;
	word_t fwd_b;
	word_t fwd_s;

	// youngest writer of r wins
	function automatic word_t forward(input reg_idx_t r, input word_t rf_val);
		if (writes_r1(o_ex_ir) && (op_of(o_ex_ir) != OP_LOAD) && (r1_of(o_ex_ir) == r))
			return i_ex_result;
		if (writes_r1(i_mem_ir) && (r1_of(i_mem_ir) == r))
			return mem_val;
		if (writes_r1(i_wb_ir) && (r1_of(i_wb_ir) == r))
			return i_wb_result;
		return rf_val;
	endfunction

	assign op = op_of(i_id_ir);
	assign mem_val = (op_of(i_mem_ir) == OP_LOAD) ? i_ddata : i_mem_result;

	always_comb
	begin
		use_a = 1'b0;
		use_b = 1'b0;
		use_s = 1'b0;
		a_is_r1 = 1'b0;
		imm = '0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
			begin
				use_a = 1'b1;
				use_b = 1'b1;
			end
			OP_LOAD, OP_STORE:
			begin
				use_a = 1'b1;
				use_s = (op == OP_STORE);
				imm = word_t'(i_id_ir[3:0]); // zero-extended offset
			end
			OP_ADDI, OP_BZ, OP_BNZ:
			begin
				use_a = 1'b1;
				a_is_r1 = 1'b1;
				imm = word_t'(i_id_ir[7:0]);
			end
			OP_LDIH:
			begin
				use_a = 1'b1;
				a_is_r1 = 1'b1;
				imm = {i_id_ir[7:0], 8'd0};
			end
			default:
				imm = '0;
		endcase
	end

	assign o_rd_a = a_is_r1 ? r1_of(i_id_ir) : r2_of(i_id_ir);
	assign o_rd_b = r3_of(i_id_ir);
	assign o_rd_s = r1_of(i_id_ir);

	always_comb
	begin
		fwd_a = forward(o_rd_a, i_rf_a);
		fwd_b = forward(o_rd_b, i_rf_b);
		fwd_s = forward(o_rd_s, i_rf_s);
	end

	// load data only exists one stage later
	assign load_use = (op_of(o_ex_ir) == OP_LOAD)
		&& ((use_a && (r1_of(o_ex_ir) == o_rd_a))
		|| (use_b && (r1_of(o_ex_ir) == o_rd_b))
		|| (use_s && (r1_of(o_ex_ir) == o_rd_s)));
	assign o_stall = load_use;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			o_ex_ir <= NOP_IR;
		else if (i_running)
		begin
			if (i_take_branch || load_use)
				o_ex_ir <= NOP_IR;
			else
				o_ex_ir <= i_id_ir;
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_running)
		begin
			o_opa <= fwd_a;
			o_opb <= use_b ? fwd_b : imm;
			o_smdr <= fwd_s;
		end
	end

endmodule

/* hw/pcpu_execute.sv */
module pcpu_execute
(
	input logic clock,
	input logic reset,
	input logic i_running,
	input pcpu_pkg::word_t i_ex_ir,
	input pcpu_pkg::word_t i_opa,
	input pcpu_pkg::word_t i_opb,
	input pcpu_pkg::word_t i_smdr,
	output pcpu_pkg::word_t o_result,
	output logic o_take_branch,
	output pcpu_pkg::addr_t o_target,
	output pcpu_pkg::word_t o_mem_ir,
	output pcpu_pkg::word_t o_mem_result,
	output pcpu_pkg::addr_t o_daddr,
	output pcpu_pkg::word_t o_ddata,
	output logic o_dwe
);
	import pcpu_pkg::*;

	opcode_t op;
	logic sets_flags;
	logic zf;
	logic nf;
	logic dw;

	assign op = op_of(i_ex_ir);

	always_comb
	begin
		case (op)
			OP_SUB:
				o_result = i_opa - i_opb;
			OP_AND:
				o_result = i_opa & i_opb;
			OP_OR:
				o_result = i_opa | i_opb;
			OP_XOR:
				o_result = i_opa ^ i_opb;
			default:
				o_result = i_opa + i_opb; // add, immediates, address sums
		endcase
	end

	always_comb
	begin
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LDIH:
				sets_flags = 1'b1;
			default:
				sets_flags = 1'b0;
		endcase
	end

	// flags as left by the last flag-setting op
	assign o_take_branch = ((op == OP_BZ) && zf) || ((op == OP_BNZ) && !zf);
	assign o_target = addr_t'(o_result);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			zf <= 1'b0;
			nf <= 1'b0;
			o_mem_ir <= NOP_IR;
			dw <= 1'b0;
		end
		else if (i_running)
		begin
			if (sets_flags)
			begin
				zf <= (o_result == '0);
				nf <= o_result[$bits(word_t)-1];
			end
			o_mem_ir <= i_ex_ir;
			dw <= (op == OP_STORE);
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_running)
		begin
			o_mem_result <= o_result;
			o_ddata <= i_smdr;
		end
	end

	assign o_daddr = addr_t'(o_mem_result);
	assign o_dwe = dw && i_running; // no write while the pipe is frozen

endmodule

/* hw/pcpu_fetch.sv */
module pcpu_fetch
(
	input logic clock,
	input logic reset,
	input logic i_enable,
	input logic i_start,
	input pcpu_pkg::word_t i_idata,
	input logic i_stall,
	input logic i_take_branch,
	input pcpu_pkg::addr_t i_target,
	input logic i_halted,
	output logic o_running,
	output pcpu_pkg::addr_t o_iaddr,
	output pcpu_pkg::word_t o_id_ir
);
	import pcpu_pkg::*;

	run_state_t state;
	run_state_t state_next;
	addr_t pc;

	assign o_running = (state == RUN_EXEC);
	assign o_iaddr = pc;

	always_comb
	begin
		state_next = state;
		case (state)
			RUN_IDLE:
				if (i_enable && i_start)
					state_next = RUN_EXEC;
			RUN_EXEC:
				if (!i_enable || i_halted) // halt seen in write-back
					state_next = RUN_IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= RUN_IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			pc <= '0;
			o_id_ir <= NOP_IR;
		end
		else if (o_running)
		begin
			if (i_take_branch)
			begin
				pc <= i_target;
				o_id_ir <= NOP_IR; // squash wrong path
			end
			else if (op_of(o_id_ir) == OP_JUMP)
			begin
				pc <= addr_t'(o_id_ir[7:0]);
				o_id_ir <= NOP_IR;
			end
			else if ((op_of(o_id_ir) != OP_HALT) && !i_stall)
			begin
				pc <= pc + 1'b1;
				o_id_ir <= i_idata;
			end
		end
	end

endmodule

/* hw/pcpu_pkg.sv */
`include "pcpu_defs.svh"

package pcpu_pkg;

	typedef logic [`PCPU_WORD_W-1:0] word_t;
	typedef logic [`PCPU_ADDR_W-1:0] addr_t;
	typedef logic [`PCPU_REG_W-1:0] reg_idx_t;

	typedef enum logic [`PCPU_OP_W-1:0]
	{
		OP_NOP = 5'b00000,
		OP_HALT = 5'b00001,
		OP_LOAD = 5'b00010,
		OP_STORE = 5'b00011,
		OP_ADD = 5'b01000,
		OP_ADDI = 5'b01001,
		OP_SUB = 5'b01010,
		OP_AND = 5'b01101,
		OP_OR = 5'b01110,
		OP_XOR = 5'b01111,
		OP_LDIH = 5'b10000,
		OP_JUMP = 5'b11000,
		OP_BZ = 5'b11010,
		OP_BNZ = 5'b11011
	} opcode_t;

	typedef enum logic
	{
		RUN_IDLE = 1'b0,
		RUN_EXEC = 1'b1
	} run_state_t;

	// bubble inserted on flush and stall
	localparam word_t NOP_IR = {OP_NOP, {(`PCPU_WORD_W-`PCPU_OP_W){1'b0}}};

	function automatic opcode_t op_of(input word_t ir);
		return opcode_t'(ir[`PCPU_WORD_W-1 -: `PCPU_OP_W]);
	endfunction

	function automatic reg_idx_t r1_of(input word_t ir);
		return ir[10:8]; // destination, branch base
	endfunction

	function automatic reg_idx_t r2_of(input word_t ir);
		return ir[6:4];
	endfunction

	function automatic reg_idx_t r3_of(input word_t ir);
		return ir[2:0];
	endfunction

	function automatic logic writes_r1(input word_t ir);
		case (op_of(ir))
			OP_LOAD, OP_LDIH, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

endpackage

/* hw/pcpu_retire.sv */
`include "pcpu_defs.svh"

module pcpu_retire
(
	input logic clock,
	input logic reset,
	input logic i_running,
	input pcpu_pkg::word_t i_mem_ir,
	input pcpu_pkg::word_t i_mem_result,
	input pcpu_pkg::word_t i_ddata,
	input pcpu_pkg::reg_idx_t i_rd_a,
	input pcpu_pkg::reg_idx_t i_rd_b,
	input pcpu_pkg::reg_idx_t i_rd_s,
	output pcpu_pkg::word_t o_wb_ir,
	output pcpu_pkg::word_t o_wb_result,
	output pcpu_pkg::word_t o_rf_a,
	output pcpu_pkg::word_t o_rf_b,
	output pcpu_pkg::word_t o_rf_s,
	output logic o_halted
);
	import pcpu_pkg::*;

	word_t regs [`PCPU_NREGS];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			o_wb_ir <= NOP_IR;
			for (int i = 0; i < `PCPU_NREGS; i++)
				regs[i] <= '0;
		end
		else if (i_running)
		begin
			o_wb_ir <= i_mem_ir;
			if (writes_r1(o_wb_ir))
				regs[r1_of(o_wb_ir)] <= o_wb_result;
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_running)
			o_wb_result <= (op_of(i_mem_ir) == OP_LOAD) ? i_ddata : i_mem_result;
	end

	assign o_rf_a = regs[i_rd_a];
	assign o_rf_b = regs[i_rd_b];
	assign o_rf_s = regs[i_rd_s]; // store data
	assign o_halted = (op_of(o_wb_ir) == OP_HALT);

endmodule

/* hw/pcpu_top.sv */
module pcpu_top
(
	input logic clock,
	input logic reset,
	input logic i_enable,
	input logic i_start,
	input pcpu_pkg::word_t i_idata,
	input pcpu_pkg::word_t i_ddata,
	output pcpu_pkg::addr_t o_iaddr,
	output pcpu_pkg::addr_t o_daddr,
	output pcpu_pkg::word_t o_ddata,
	output logic o_dwe
);
	import pcpu_pkg::*;

	logic running;
	logic stall;
	logic take_branch;
	logic halted;
	addr_t target;
	reg_idx_t rd_a;
	reg_idx_t rd_b;
	reg_idx_t rd_s;
	word_t id_ir;
	word_t ex_ir;
	word_t opa;
	word_t opb;
	word_t smdr;
	word_t ex_result;
	word_t mem_ir;
	word_t mem_result;
	word_t wb_ir;
	word_t wb_result;
	word_t rf_a;
	word_t rf_b;
	word_t rf_s;

	pcpu_fetch fetch_i
	(
		.clock(clock),
		.reset(reset),
		.i_enable(i_enable),
		.i_start(i_start),
		.i_idata(i_idata),
		.i_stall(stall),
		.i_take_branch(take_branch),
		.i_target(target),
		.i_halted(halted),
		.o_running(running),
		.o_iaddr(o_iaddr),
		.o_id_ir(id_ir)
	);

	pcpu_decode decode_i
	(
		.clock(clock),
		.reset(reset),
		.i_running(running),
		.i_id_ir(id_ir),
		.i_take_branch(take_branch),
		.i_ex_result(ex_result),
		.i_mem_ir(mem_ir),
		.i_mem_result(mem_result),
		.i_ddata(i_ddata),
		.i_wb_ir(wb_ir),
		.i_wb_result(wb_result),
		.i_rf_a(rf_a),
		.i_rf_b(rf_b),
		.i_rf_s(rf_s),
		.o_rd_a(rd_a),
		.o_rd_b(rd_b),
		.o_rd_s(rd_s),
		.o_stall(stall),
		.o_ex_ir(ex_ir),
		.o_opa(opa),
		.o_opb(opb),
		.o_smdr(smdr)
	);

	pcpu_execute execute_i
	(
		.clock(clock),
		.reset(reset),
		.i_running(running),
		.i_ex_ir(ex_ir),
		.i_opa(opa),
		.i_opb(opb),
		.i_smdr(smdr),
		.o_result(ex_result),
		.o_take_branch(take_branch),
		.o_target(target),
		.o_mem_ir(mem_ir),
		.o_mem_result(mem_result),
		.o_daddr(o_daddr),
		.o_ddata(o_ddata),
		.o_dwe(o_dwe)
	);

	pcpu_retire retire_i
	(
		.clock(clock),
		.reset(reset),
		.i_running(running),
		.i_mem_ir(mem_ir),
		.i_mem_result(mem_result),
		.i_ddata(i_ddata),
		.i_rd_a(rd_a),
		.i_rd_b(rd_b),
		.i_rd_s(rd_s),
		.o_wb_ir(wb_ir),
		.o_wb_result(wb_result),
		.o_rf_a(rf_a),
		.o_rf_b(rf_b),
		.o_rf_s(rf_s),
		.o_halted(halted)
	);

endmodule

/* include/pcpu_defs.svh */
`ifndef PCPU_DEFS_SVH
`define PCPU_DEFS_SVH

// data and instruction word
`define PCPU_WORD_W 16

// instruction and data address
`define PCPU_ADDR_W 8

// general register file
`define PCPU_NREGS 8
`define PCPU_REG_W 3

// opcode field, top of the instruction word
`define PCPU_OP_W 5

`endif

/* project.f */
+incdir+include
hw/pcpu_pkg.sv
hw/pcpu_fetch.sv
hw/pcpu_decode.sv
hw/pcpu_execute.sv
hw/pcpu_retire.sv
hw/pcpu_top.sv
tests/pcpu_tb.sv

/* tests/pcpu_tb.sv */
module pcpu_tb;
	import pcpu_pkg::*;

	logic clock;
	logic reset;
	logic i_enable;
	logic i_start;
	word_t i_idata;
	word_t i_ddata;
	addr_t o_iaddr;
	addr_t o_daddr;
	word_t o_ddata;
	logic o_dwe;

	word_t imem [256];
	word_t dmem [256];
	word_t prog [$];
	addr_t exp_addr [$];
	word_t exp_data [$];
	logic [31:0] lfsr;
	int errors;
	int errors_at_start;
	int tests;
	int failed_tests;
	int cycles;
	int limit;
	bit forbid_stores;
	bit idle_check;
	string test_name;

	pcpu_top pcpu_top_i
	(
		.clock(clock),
		.reset(reset),
		.i_enable(i_enable),
		.i_start(i_start),
		.i_idata(i_idata),
		.i_ddata(i_ddata),
		.o_iaddr(o_iaddr),
		.o_daddr(o_daddr),
		.o_ddata(o_ddata),
		.o_dwe(o_dwe)
	);

	// both memories answer in the same cycle
	assign i_idata = imem[o_iaddr];
	assign i_ddata = dmem[o_daddr];

	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		if (o_dwe)
			dmem[o_daddr] <= o_ddata;
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout in %s: the run did not end after %0d cycles", test_name, limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(posedge clock)
	begin
		if (idle_check)
		begin
			assert (!o_dwe && (o_iaddr == '0))
			else
			begin
				errors++;
				$display("%s: DUT active before start, iaddr %h dwe %b", test_name, o_iaddr,
					o_dwe);
			end
		end
		if (!reset && o_dwe)
		begin
			assert (!forbid_stores)
			else
			begin
				errors++;
				$display("%s: store to %h after the run ended", test_name, o_daddr);
			end
			if (exp_addr.size() == 0)
			begin
				errors++;
				$display("%s: store to %h that the program does not make", test_name, o_daddr);
			end
			else
			begin
				assert (o_daddr == exp_addr[0])
				else
				begin
					errors++;
					$display("CHECK FAILED %s address: expected %h actual %h", test_name,
						exp_addr[0], o_daddr);
				end
				assert (o_ddata == exp_data[0])
				else
				begin
					errors++;
					$display("CHECK FAILED %s data: expected %h actual %h", test_name,
						exp_data[0], o_ddata);
				end
				exp_addr.delete(0);
				exp_data.delete(0);
			end
		end
	end

	// galois form stepped once per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'hB4BC_D35C : 32'h0);
		return b;
	endfunction

	function automatic word_t rand_word();
		word_t v;
		v = '0;
		for (int i = 0; i < 16; i++)
			v = {v[14:0], lfsr_bit()};
		return v;
	endfunction

	function automatic word_t enc_r(opcode_t op, int d, int a, int b);
		return {op, 3'(d), 1'b0, 3'(a), 1'b0, 3'(b)};
	endfunction

	function automatic word_t enc_i(opcode_t op, int d, int imm);
		return {op, 3'(d), 8'(imm)};
	endfunction

	function automatic word_t enc_m(opcode_t op, int d, int a, int off);
		return {op, 3'(d), 1'b0, 3'(a), 4'(off)};
	endfunction

	task automatic emit(input word_t w);
		prog.push_back(w);
	endtask

	task automatic load_const(input int r, input word_t v);
		emit(enc_r(OP_XOR, r, r, r));
		emit(enc_i(OP_LDIH, r, v[15:8]));
		emit(enc_i(OP_ADDI, r, v[7:0]));
	endtask

	// runs the program in imem by the ISA rules and lists its stores
	task automatic model_run();
		word_t r [8];
		word_t mem [256];
		logic zf;
		addr_t pc;
		word_t w;
		word_t v;
		reg_idx_t d;
		reg_idx_t a;
		reg_idx_t b;
		int steps;
		bit done;
		mem = dmem;
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		zf = 1'b0;
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done && (steps < 1000))
		begin
			w = imem[pc];
			pc = pc + 8'd1;
			steps++;
			d = w[10:8];
			a = w[6:4];
			b = w[2:0];
			case (w[15:11])
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LDIH:
				begin
					case (w[15:11])
						OP_ADD: v = r[a] + r[b];
						OP_SUB: v = r[a] - r[b];
						OP_AND: v = r[a] & r[b];
						OP_OR: v = r[a] | r[b];
						OP_XOR: v = r[a] ^ r[b];
						OP_ADDI: v = r[d] + {8'h00, w[7:0]};
						default: v = r[d] + {w[7:0], 8'h00};
					endcase
					r[d] = v;
					zf = (v == '0);
				end
				OP_LOAD:
				begin
					v = r[a] + {12'h000, w[3:0]};
					r[d] = mem[v[7:0]];
				end
				OP_STORE:
				begin
					v = r[a] + {12'h000, w[3:0]};
					exp_addr.push_back(v[7:0]);
					exp_data.push_back(r[d]);
					mem[v[7:0]] = r[d];
				end
				OP_JUMP:
					pc = w[7:0];
				OP_BZ, OP_BNZ:
				begin
					v = r[d] + {8'h00, w[7:0]};
					if (zf == (w[15:11] == OP_BZ))
						pc = v[7:0];
				end
				OP_HALT:
					done = 1'b1;
				default:
					v = '0;
			endcase
		end
	endtask

	task automatic load_test(input string name);
		@(posedge clock);
		reset <= 1'b1;
		i_start <= 1'b0;
		i_enable <= 1'b1;
		test_name = name;
		errors_at_start = errors;
		forbid_stores = 1'b0;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 256; i++)
		begin
			imem[i] = (i < prog.size()) ? prog[i] : enc_i(OP_HALT, 0, 0);
			dmem[i] = {~8'(i), 8'(i)} ^ 16'h5a00;
		end
		model_run();
		cycles = 0;
		limit = 64 * prog.size() + 200;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
	endtask

	task automatic start_run();
		@(posedge clock);
		i_start <= 1'b1;
		@(posedge clock);
		i_start <= 1'b0;
		@(posedge clock);
	endtask

	task automatic wait_done();
		while (pcpu_top_i.running)
			@(posedge clock);
		forbid_stores <= 1'b1;
	endtask

	task automatic check_frozen(input int n);
		addr_t a;
		a = o_iaddr;
		repeat (n)
		begin
			@(posedge clock);
			assert (o_iaddr == a)
			else
			begin
				errors++;
				$display("CHECK FAILED %s iaddr: expected %h actual %h", test_name, a, o_iaddr);
			end
		end
	endtask

	task automatic end_test(input bit all_stores);
		if (all_stores)
		begin
			assert (exp_addr.size() == 0)
			else
			begin
				errors++;
				$display("CHECK FAILED %s missing stores: expected 0 actual %0d", test_name,
					exp_addr.size());
			end
		end
		tests++;
		if (errors != errors_at_start)
			failed_tests++;
		$display("%s: %s", test_name, (errors == errors_at_start) ? "passed" : "failed");
	endtask

	task automatic run_simple(input string name);
		load_test(name);
		start_run();
		wait_done();
		check_frozen(10);
		end_test(1'b1);
	endtask

	initial
	begin
		int p;
		int n;
		clock = 1'b0;
		reset = 1'b1;
		i_enable = 1'b0;
		i_start = 1'b0;
		lfsr = 32'h1419_a1cc;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		cycles = 0;
		limit = 1000;
		idle_check = 1'b0;
		forbid_stores = 1'b0;
		for (int i = 0; i < 256; i++)
		begin
			imem[i] = '0;
			dmem[i] = '0;
		end

		prog.delete();
		emit(enc_m(OP_STORE, 0, 0, 1));
		emit(enc_i(OP_HALT, 0, 0));
		load_test("idle_after_reset");
		idle_check <= 1'b1;
		repeat (12) @(posedge clock);
		idle_check <= 1'b0;
		end_test(1'b0);

		prog.delete();
		load_const(1, rand_word());
		load_const(2, rand_word());
		emit(enc_r(OP_ADD, 3, 1, 2));
		emit(enc_r(OP_SUB, 4, 3, 1));
		emit(enc_r(OP_AND, 5, 4, 3));
		emit(enc_r(OP_OR, 6, 5, 4));
		emit(enc_r(OP_XOR, 7, 6, 5));
		emit(enc_m(OP_STORE, 7, 0, 1));
		emit(enc_m(OP_STORE, 6, 0, 2));
		emit(enc_m(OP_STORE, 5, 0, 3));
		emit(enc_m(OP_STORE, 4, 0, 4));
		emit(enc_m(OP_STORE, 3, 0, 5));
		emit(enc_r(OP_ADD, 3, 7, 1));
		emit(enc_m(OP_STORE, 3, 0, 6)); // store data straight from execute
		emit(enc_i(OP_HALT, 0, 0));
		run_simple("alu_chain");

		prog.delete();
		load_const(1, rand_word());
		emit(enc_m(OP_STORE, 1, 0, 2));
		emit(enc_m(OP_LOAD, 2, 0, 2));
		emit(enc_r(OP_ADD, 3, 2, 1));
		emit(enc_m(OP_STORE, 3, 0, 3));
		emit(enc_m(OP_LOAD, 4, 0, 7));
		emit(enc_m(OP_STORE, 4, 0, 8));
		emit(enc_m(OP_LOAD, 5, 0, 8));
		emit(enc_r(OP_ADD, 6, 5, 5));
		emit(enc_m(OP_STORE, 6, 0, 9));
		emit(enc_i(OP_HALT, 0, 0));
		run_simple("load_use");

		prog.delete();
		load_const(1, rand_word() | 16'h0001);
		emit(enc_r(OP_XOR, 2, 2, 2));
		p = prog.size();
		emit(enc_i(OP_BZ, 0, p + 3)); // taken
		emit(enc_m(OP_STORE, 1, 0, 15));
		emit(enc_m(OP_STORE, 1, 0, 14));
		emit(enc_m(OP_STORE, 1, 0, 1));
		emit(enc_r(OP_ADD, 3, 1, 0));
		emit(enc_i(OP_BZ, 0, prog.size() + 2)); // not taken
		emit(enc_m(OP_STORE, 3, 0, 2));
		p = prog.size();
		emit(enc_i(OP_BNZ, 0, p + 3));
		emit(enc_m(OP_STORE, 1, 0, 15));
		emit(enc_m(OP_STORE, 1, 0, 14));
		emit(enc_m(OP_STORE, 3, 0, 3));
		emit(enc_r(OP_SUB, 4, 1, 1));
		emit(enc_i(OP_BNZ, 0, prog.size() + 2));
		emit(enc_m(OP_STORE, 4, 0, 4));
		p = prog.size();
		emit(enc_i(OP_JUMP, 0, p + 3));
		emit(enc_m(OP_STORE, 1, 0, 15));
		emit(enc_m(OP_STORE, 1, 0, 14));
		emit(enc_m(OP_STORE, 1, 0, 5));
		emit(enc_r(OP_XOR, 5, 5, 5));
		emit(enc_i(OP_ADDI, 5, 2));
		p = prog.size();
		emit(enc_i(OP_BNZ, 5, p + 1)); // base register plus offset
		emit(enc_m(OP_STORE, 1, 0, 15));
		emit(enc_m(OP_STORE, 1, 0, 14));
		emit(enc_m(OP_STORE, 5, 0, 6));
		emit(enc_i(OP_HALT, 0, 0));
		run_simple("control_flow");

		prog.delete();
		load_const(1, rand_word());
		emit(enc_m(OP_STORE, 1, 0, 1));
		emit(enc_i(OP_HALT, 0, 0));
		emit(enc_m(OP_STORE, 1, 0, 2));
		emit(enc_m(OP_STORE, 1, 0, 3));
		load_test("halt_and_restart");
		start_run();
		wait_done();
		check_frozen(10);
		start_run(); // a halted program must stay halted
		check_frozen(10);
		end_test(1'b1);

		prog.delete();
		load_const(1, rand_word());
		for (int k = 0; k < 24; k++)
		begin
			emit(enc_i(OP_ADDI, 1, k + 1));
			emit(enc_m(OP_STORE, 1, 0, k % 16));
		end
		emit(enc_i(OP_HALT, 0, 0));
		load_test("enable_drop");
		n = exp_addr.size();
		start_run();
		while (exp_addr.size() > n - 3)
			@(posedge clock);
		i_enable <= 1'b0;
		repeat (2) @(posedge clock);
		forbid_stores <= 1'b1;
		check_frozen(20);
		end_test(1'b0);

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
